// File: source/mipsIsaPkg.sv
package mipsIsaPkg;

    // Instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    localparam int SHAMT_LSB = 6;   // Funct sits below this
    localparam int SHAMT_WIDTH = 5;
    localparam int IMM_WIDTH = 16;
    localparam int TARGET_WIDTH = 26;

    localparam int REG_COUNT = 32;

    typedef logic [4:0] regIndex_t;

    localparam regIndex_t V0_INDEX = 5'd2;  // Result register seen at the top

    // Major opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,  // R-type, decoded by funct
        OP_J = 6'd2,
        OP_BEQ = 6'd4,
        OP_BNE = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI = 6'd12,
        OP_ORI = 6'd13,
        OP_XORI = 6'd14,
        OP_LUI = 6'd15,
        OP_LW = 6'd35,
        OP_SW = 6'd43
    } opcode_t;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL = 6'd0,
        FN_SRL = 6'd2,
        FN_SRA = 6'd3,
        FN_JR = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND = 6'd36,
        FN_OR = 6'd37,
        FN_XOR = 6'd38,
        FN_SLT = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,    // Also the BEQ/BNE compare
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI     // Immediate into upper half
    } aluOp_t;

endpackage

// File: source/cpuBusPkg.sv
package cpuBusPkg;

    typedef logic [31:0] word_t;    // Data word and byte address

    // Boot ROM start, kseg1
    localparam word_t RESET_VECTOR = 32'hBFC0_0000;

    // Jumping here stops the core
    localparam word_t HALT_ADDRESS = 32'h0000_0000;

    // Word accesses only
    localparam logic [3:0] BYTE_ENABLE_ALL = 4'b1111;

    typedef enum logic [1:0] {
        FETCH,      // Instruction read on the bus
        EXECUTE,    // Decode, ALU, branch resolve
        MEMORY,     // LW/SW data access
        HALT
    } cpuState_t;

endpackage

// File: source/datapathIfs.sv
interface regFileIf;
    import mipsIsaPkg::*;
    import cpuBusPkg::*;

    regIndex_t readAddrA;   // rs
    regIndex_t readAddrB;   // rt
    word_t readDataA;
    word_t readDataB;
    logic writeEnable;
    regIndex_t writeAddr;
    word_t writeData;

    modport controller (output readAddrA, readAddrB, writeEnable, writeAddr, writeData,
                        input readDataA, readDataB);
    modport regs (input readAddrA, readAddrB, writeEnable, writeAddr, writeData,
                  output readDataA, readDataB);
endinterface

interface aluIf;
    import mipsIsaPkg::*;
    import cpuBusPkg::*;

    aluOp_t op;
    word_t operandA;
    word_t operandB;
    logic [SHAMT_WIDTH-1:0] shamt;  // Constant shift amount only
    word_t result;
    logic zero;

    modport controller (output op, operandA, operandB, shamt, input result, zero);
    modport unit (input op, operandA, operandB, shamt, output result, zero);
endinterface

// File: source/registerFile.sv
module registerFile (
    input logic clk,
    input logic reset,
    regFileIf.regs regs,
    output cpuBusPkg::word_t v0
);
    import mipsIsaPkg::*;
    import cpuBusPkg::*;

    word_t regBank [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regBank[i] <= '0;
            end
        end else if (regs.writeEnable && regs.writeAddr != '0) begin // $zero stays zero
            regBank[regs.writeAddr] <= regs.writeData;
        end
    end

    // Asynchronous read ports
    assign regs.readDataA = regBank[regs.readAddrA];
    assign regs.readDataB = regBank[regs.readAddrB];

    assign v0 = regBank[V0_INDEX];

    // Register 0 must never leak a stored value, whatever the controller writes
    zeroRegisterReads : assert property (
        @(posedge clk) disable iff (reset)
        regs.readAddrA == '0 |-> regs.readDataA == '0
    );

endmodule

// File: source/alu.sv
module alu (
    aluIf.unit aluPort
);
    import mipsIsaPkg::*;

    always_comb begin
        case (aluPort.op)
            ALU_ADD: aluPort.result = aluPort.operandA + aluPort.operandB;
            ALU_SUB: aluPort.result = aluPort.operandA - aluPort.operandB;
            ALU_AND: aluPort.result = aluPort.operandA & aluPort.operandB;
            ALU_OR: aluPort.result = aluPort.operandA | aluPort.operandB;
            ALU_XOR: aluPort.result = aluPort.operandA ^ aluPort.operandB;
            ALU_SLT: begin
                // Signed compare
                aluPort.result = '0;
                aluPort.result[0] = $signed(aluPort.operandA) < $signed(aluPort.operandB);
            end
            ALU_SLTU: begin
                aluPort.result = '0;
                aluPort.result[0] = aluPort.operandA < aluPort.operandB;
            end
            // Shifts act on rt, which arrives as operandB
            ALU_SLL: aluPort.result = aluPort.operandB << aluPort.shamt;
            ALU_SRL: aluPort.result = aluPort.operandB >> aluPort.shamt;
            ALU_SRA: aluPort.result = $signed(aluPort.operandB) >>> aluPort.shamt;
            ALU_LUI: begin
                aluPort.result = {aluPort.operandB[IMM_WIDTH-1:0], {IMM_WIDTH{1'b0}}};
            end
            default: aluPort.result = '0;
        endcase
    end

    assign aluPort.zero = aluPort.result == '0;   // Equal operands under SUB

endmodule

// File: source/cpuController.sv
module cpuController (
    input logic clk,
    input logic reset,
    input logic waitrequest,
    input cpuBusPkg::word_t readdata,
    output cpuBusPkg::word_t address,
    output cpuBusPkg::word_t writedata,
    output logic read,
    output logic write,
    output logic active,
    output logic [3:0] byteenable,
    regFileIf.controller regs,
    aluIf.controller aluPort
);
    import mipsIsaPkg::*;
    import cpuBusPkg::*;

    cpuState_t state;
    word_t pc;              // Address of the instruction in flight
    word_t instr;
    logic slotPending;      // Current instruction is a delay slot
    word_t pendingTarget;   // Where to go after the slot

    opcode_t opcode;
    funct_t funct;
    regIndex_t rs, rt, rd;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [IMM_WIDTH-1:0] imm;
    logic [TARGET_WIDTH-1:0] target;

    aluOp_t aluOp;
    logic aluWrite;         // Result goes to the register file
    logic isRType, isLoad, isStore, useImm, signExt;
    logic transfer, retire;
    word_t pcPlus4, immExt, branchTarget, jumpTarget, transferTarget, nextPc;

    // Field split
    assign opcode = opcode_t'(instr[$bits(word_t)-1:OPCODE_LSB]);
    assign rs = regIndex_t'(instr >> RS_LSB);
    assign rt = regIndex_t'(instr >> RT_LSB);
    assign rd = regIndex_t'(instr >> RD_LSB);
    assign shamt = instr[SHAMT_LSB +: SHAMT_WIDTH];
    assign funct = funct_t'(instr[SHAMT_LSB-1:0]);
    assign imm = instr[IMM_WIDTH-1:0];
    assign target = instr[TARGET_WIDTH-1:0];

    assign isRType = opcode == OP_SPECIAL;
    assign isLoad = opcode == OP_LW;
    assign isStore = opcode == OP_SW;
    assign useImm = !isRType && !(opcode inside {OP_BEQ, OP_BNE});
    assign signExt = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI}); // Logic ops zero-extend

    always_comb begin
        aluOp = ALU_ADD;    // Also the LW/SW address add
        aluWrite = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL: aluOp = ALU_SLL;
                    FN_SRL: aluOp = ALU_SRL;
                    FN_SRA: aluOp = ALU_SRA;
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND: aluOp = ALU_AND;
                    FN_OR: aluOp = ALU_OR;
                    FN_XOR: aluOp = ALU_XOR;
                    FN_SLT: aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    default: aluWrite = 1'b0;   // JR and unknown functs
                endcase
            end
            OP_ADDIU: aluOp = ALU_ADD;
            OP_SLTI: aluOp = ALU_SLT;
            OP_SLTIU: aluOp = ALU_SLTU;
            OP_ANDI: aluOp = ALU_AND;
            OP_ORI: aluOp = ALU_OR;
            OP_XORI: aluOp = ALU_XOR;
            OP_LUI: aluOp = ALU_LUI;
            OP_BEQ, OP_BNE: begin
                aluOp = ALU_SUB;    // Compare through zero flag
                aluWrite = 1'b0;
            end
            default: aluWrite = 1'b0;   // J, LW, SW, unknown
        endcase
    end

    assign immExt = signExt ? {{($bits(word_t)-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm}
                            : {{($bits(word_t)-IMM_WIDTH){1'b0}}, imm};

    assign regs.readAddrA = rs;
    assign regs.readAddrB = rt;
    assign aluPort.op = aluOp;
    assign aluPort.operandA = regs.readDataA;
    assign aluPort.operandB = useImm ? immExt : regs.readDataB;
    assign aluPort.shamt = shamt;

    // ALU results land in EXECUTE, load data once the bus completes
    assign regs.writeEnable = (state == EXECUTE && aluWrite)
                              || (state == MEMORY && isLoad && !waitrequest);
    assign regs.writeAddr = isRType ? rd : rt;
    assign regs.writeData = isLoad ? readdata : aluPort.result;

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + (immExt << 2);
    assign jumpTarget = {pcPlus4[$bits(word_t)-1:TARGET_WIDTH+2], target, 2'b00};
    assign transfer = (opcode == OP_BEQ && aluPort.zero)
                      || (opcode == OP_BNE && !aluPort.zero)
                      || opcode == OP_J
                      || (isRType && funct == FN_JR);
    assign transferTarget = (opcode == OP_J) ? jumpTarget
                          : isRType ? regs.readDataA    // JR
                          : branchTarget;

    // Instruction done, PC may move
    assign retire = (state == EXECUTE && !(isLoad || isStore))
                    || (state == MEMORY && !waitrequest);
    assign nextPc = slotPending ? pendingTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc <= RESET_VECTOR;
            slotPending <= 1'b0;
        end else begin
            if (state == FETCH && !waitrequest) begin
                state <= EXECUTE;
            end else if (state == EXECUTE && (isLoad || isStore)) begin
                state <= MEMORY;
            end
            if (retire) begin
                pc <= nextPc;
                slotPending <= transfer;    // Next instruction is the delay slot
                // Slot done and target is zero, stop here
                state <= (slotPending && pendingTarget == HALT_ADDRESS) ? HALT : FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            instr <= readdata;
        end
        if (retire && transfer) begin
            pendingTarget <= transferTarget;
        end
    end

    // Bus side
    assign read = state == FETCH || (state == MEMORY && isLoad);
    assign write = state == MEMORY && isStore;
    assign address = (state == MEMORY) ? aluPort.result : pc;   // rs + offset for data
    assign writedata = regs.readDataB;
    assign byteenable = BYTE_ENABLE_ALL;
    assign active = state != HALT;

    noReadWithWrite : assert property (
        @(posedge clk) disable iff (reset)
        !(read && write)
    );

    // Stalled access keeps its address and strobe
    stableUnderWait : assert property (
        @(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable({read, write})
    );

endmodule

// File: source/mipsCpuBus.sv
module mipsCpuBus (
    input logic clk,
    input logic reset,
    output logic active,
    output cpuBusPkg::word_t register_v0,

    // Avalon-MM master
    output cpuBusPkg::word_t address,
    output logic write,
    output logic read,
    input logic waitrequest,
    output cpuBusPkg::word_t writedata,
    output logic [3:0] byteenable,
    input cpuBusPkg::word_t readdata
);

    regFileIf regBus ();
    aluIf aluBus ();

    cpuController controller (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .address(address),
        .writedata(writedata),
        .read(read),
        .write(write),
        .active(active),
        .byteenable(byteenable),
        .regs(regBus.controller),
        .aluPort(aluBus.controller)
    );

    registerFile regFile (
        .clk(clk),
        .reset(reset),
        .regs(regBus.regs),
        .v0(register_v0)
    );

    alu aluUnit (
        .aluPort(aluBus.unit)
    );

endmodule

// File: testbench/memoryModel.sv
module memoryModel (
    input logic clk,
    input logic reset,
    input logic randomWait,         // Draw waitrequest from the LCG
    input logic [15:0][31:0] code,  // Program image at the reset vector
    input logic [31:0] address,
    input logic read,
    input logic write,
    input logic [31:0] writedata,
    input logic [3:0] byteenable,
    output logic waitrequest,
    output logic [31:0] readdata,
    input logic [31:0] peekAddress, // Backdoor for result checks
    output logic [31:0] peekData
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = 64;      // Indexed by address bits 7:2 so higher bits alias
    localparam logic [31:0] IDLE_DATA = 32'hBAD0_0BAD; // Bus value when nothing is read

    logic [31:0] words [WORDS];
    logic [31:0] lcgState = 32'h8375_21c1;
    logic waitDraw = 1'b0;
    logic [31:0] laneMask;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Differs per word so a partial or misplaced write shows up
    function automatic logic [31:0] fillWord(input int index);
        return 32'hC3A5_0000 ^ (32'(index) * 32'h0107_0B13);
    endfunction

    assign laneMask = {{8{byteenable[3]}}, {8{byteenable[2]}},
                       {8{byteenable[1]}}, {8{byteenable[0]}}};

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < WORDS; i++) begin
                words[6'(i)] <= (i < 16) ? code[4'(i)] : fillWord(i);
            end
        end else if (write && !waitrequest) begin
            words[address[7:2]] <= (words[address[7:2]] & ~laneMask) | (writedata & laneMask);
        end
    end

    // Zero-latency read, data only while read is high
    assign readdata = read ? words[address[7:2]] : IDLE_DATA;
    assign peekData = words[peekAddress[7:2]];
    assign waitrequest = waitDraw;

    // New stall decision on each falling edge for the next rising edge
    always @(negedge clk) begin
        lcgState <= nextRandom(lcgState);
        waitDraw <= randomWait && lcgState[31];   // Top bit since the low ones cycle fast
    end

endmodule

// File: testbench/mipsCpuBusTb.sv
module mipsCpuBusTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsIsaPkg::*;
    import cpuBusPkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RUN_TIMEOUT = 2000;  // Cycles until active must fall
    localparam int HALT_WATCH = 20;
    localparam word_t DATA_ADDRESS = 32'h0000_0080;

    typedef struct packed {
        logic [15:0][31:0] code;    // Word i at RESET_VECTOR + 4*i
        logic randomWait;
        word_t expectV0;
        logic checkData;            // expectData valid at DATA_ADDRESS
        word_t expectData;
    } testEntry_t;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic randomWait = 1'b0;
    logic [15:0][31:0] currentCode = '0;
    logic active, read, write, waitrequest;
    logic [3:0] byteenable;
    word_t registerV0, address, writedata, readdata, peekData;

    testEntry_t tests[$];
    string testNames[$];
    word_t progBuf[$];      // Program under construction
    int errorCount = 0;
    int checkCount = 0;

    mipsCpuBus DUT (
        .clk(clk), .reset(reset), .active(active), .register_v0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    memoryModel mem (
        .clk(clk), .reset(reset), .randomWait(randomWait), .code(currentCode),
        .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .waitrequest(waitrequest), .readdata(readdata),
        .peekAddress(DATA_ADDRESS), .peekData(peekData)
    );

    always #50 clk = ~clk;

    function automatic word_t rType(input int rs, input int rt, input int rd, input int shamt,
                                    input logic [5:0] funct);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input int rs, input int rt,
                                    input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jType(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    // Closes progBuf with jr $zero and its slot, then files it
    task automatic addTest(input string name, input word_t v0, input logic checkData,
                           input word_t dataWord);
        testEntry_t entry;
        entry = '0;
        progBuf.push_back(rType(0, 0, 0, 0, FN_JR));
        progBuf.push_back(32'h0);   // nop
        foreach (progBuf[i]) begin
            entry.code[4'(i)] = progBuf[i];
        end
        entry.expectV0 = v0;
        entry.checkData = checkData;
        entry.expectData = dataWord;
        tests.push_back(entry);
        testNames.push_back(name);
    endtask

    task automatic buildTable();
        testEntry_t entry;
        int baseCount;
        logic useBne, equalOps, taken;
        progBuf = {iType(OP_ADDIU, 0, 8, -3), iType(OP_ADDIU, 8, 2, 10)};
        addTest("addiu", 32'h0000_0007, 1'b0, '0);     // -3 + 10
        progBuf = {iType(OP_LUI, 0, 8, 'h1234), iType(OP_ORI, 8, 2, 'hABCD)};
        addTest("lui ori", 32'h1234_ABCD, 1'b0, '0);
        progBuf = {iType(OP_ADDIU, 0, 8, 100), iType(OP_ADDIU, 0, 9, 30),
                   rType(8, 9, 10, 0, FN_ADDU), rType(9, 10, 2, 0, FN_SUBU)};
        addTest("addu subu", 32'hFFFF_FF9C, 1'b0, '0); // 30 - 130
        progBuf = {iType(OP_LUI, 0, 8, 'hF0F0), iType(OP_ORI, 8, 8, 'h00FF),
                   iType(OP_ORI, 0, 9, 'h0F0F), rType(8, 9, 10, 0, FN_AND),
                   rType(8, 10, 2, 0, FN_XOR)};
        addTest("and xor", 32'hF0F0_00F0, 1'b0, '0);
        // slt, sltu and slti land in bits 8, 4 and 0
        progBuf = {iType(OP_ADDIU, 0, 8, -1), iType(OP_ADDIU, 0, 9, 1),
                   rType(8, 9, 10, 0, FN_SLT), rType(8, 9, 11, 0, FN_SLTU),
                   iType(OP_SLTI, 8, 12, 0), rType(0, 10, 10, 8, FN_SLL),
                   rType(0, 11, 11, 4, FN_SLL), rType(10, 11, 2, 0, FN_ADDU),
                   rType(2, 12, 2, 0, FN_ADDU)};
        addTest("set less", 32'h0000_0101, 1'b0, '0);
        progBuf = {iType(OP_LUI, 0, 8, 'h8000), rType(0, 8, 9, 4, FN_SRA),
                   rType(0, 9, 10, 8, FN_SRL), rType(0, 10, 2, 3, FN_SLL)};
        addTest("shifts", 32'h07C0_0000, 1'b0, '0);
        progBuf = {iType(OP_LUI, 0, 8, 'h1357), iType(OP_ORI, 8, 8, 'h9BDF),
                   iType(OP_ADDIU, 0, 9, 'h70), iType(OP_SW, 9, 8, 'h10),
                   iType(OP_LW, 9, 2, 'h10)};
        addTest("sw lw", 32'h1357_9BDF, 1'b1, 32'h1357_9BDF);
        // Slot adds 1, fall-through 0x10, target 0x100
        for (int b = 0; b < 4; b++) begin
            useBne = b[1];
            equalOps = b[0];
            taken = useBne ? !equalOps : equalOps;
            progBuf = {iType(OP_ADDIU, 0, 8, 5), iType(OP_ADDIU, 0, 9, equalOps ? 5 : 6),
                       iType(useBne ? OP_BNE : OP_BEQ, 8, 9, 2), iType(OP_ADDIU, 2, 2, 1),
                       iType(OP_ADDIU, 2, 2, 'h10), iType(OP_ADDIU, 2, 2, 'h100)};
            addTest($sformatf("%s %s", useBne ? "bne" : "beq", taken ? "taken" : "not taken"),
                    taken ? 32'h0000_0101 : 32'h0000_0111, 1'b0, '0);
        end
        progBuf = {iType(OP_ADDIU, 0, 2, 'h20), jType(OP_J, 26'((RESET_VECTOR + 32'h10) >> 2)),
                   iType(OP_ADDIU, 2, 2, 2), iType(OP_ADDIU, 2, 2, 'h40),
                   iType(OP_ADDIU, 2, 2, 'h400)};
        addTest("j", 32'h0000_0422, 1'b0, '0);
        // Same programs again under random stalls
        baseCount = tests.size();
        for (int i = 0; i < baseCount; i++) begin
            entry = tests[i];
            entry.randomWait = 1'b1;
            tests.push_back(entry);
            testNames.push_back({testNames[i], " +wait"});
        end
    endtask

    task automatic runTest(input int idx);
        testEntry_t entry;
        int errorsBefore;
        int strobes;
        logic halted;
        entry = tests[idx];
        errorsBefore = errorCount;
        strobes = 0;
        halted = 1'b0;
        @(negedge clk);
        currentCode = entry.code;       // Memory reloads while reset is high
        randomWait = entry.randomWait;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        checkValue("active", 32'(active), 32'h1);   // Still the reset state here
        checkValue("write", 32'(write), 32'h0);
        checkValue("read", 32'(read), 32'h1);
        checkValue("address", address, RESET_VECTOR);
        for (int cycle = 0; cycle < RUN_TIMEOUT && !halted; cycle++) begin
            @(negedge clk);
            halted = !active;
        end
        if (!halted) begin
            errorCount++;
            $display("%s: active still high after %0d cycles", testNames[idx], RUN_TIMEOUT);
        end else begin
            checkValue("register_v0", registerV0, entry.expectV0);
            if (entry.checkData) begin
                checkValue("data word", peekData, entry.expectData);
            end
            repeat (HALT_WATCH) begin
                @(negedge clk);
                if (read || write || active) begin
                    strobes++;      // Halted core must stay off the bus
                end
            end
            checkValue("bus activity after halt", 32'(strobes), 32'h0);
        end
        $display("%-20s %s", testNames[idx], errorCount == errorsBefore ? "ok" : "failed");
    endtask

    // Word accesses only
    always @(negedge clk) begin
        if (write) begin
            checkValue("byteenable", 32'(byteenable), 32'h0000_000F);
        end
    end

    initial begin
        buildTable();
        for (int i = 0; i < tests.size(); i++) begin
            runTest(i);
        end
        $display("%0d tests, %0d checks, %0d errors", tests.size(), checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
source/mipsIsaPkg.sv
source/cpuBusPkg.sv
source/datapathIfs.sv
source/registerFile.sv
source/alu.sv
source/cpuController.sv
source/mipsCpuBus.sv
testbench/memoryModel.sv
testbench/mipsCpuBusTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds and runs the CPU testbench with Verilator from the project root
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps --top-module mipsCpuBusTb \
    -f sim.f -o mipsCpuBusSim \
    && ./obj_dir/mipsCpuBusSim | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "testbench reported a failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
